// File: dv/processorTb.sv
`timescale 1ns/1ps
`default_nettype none

module processorTb
  import cpuPkg::*;
();

  // program shape and cycle limits
  localparam int bodyLength   = 40;
  localparam int programCount = 6;
  localparam int haltTimeout  = 1000;
  localparam int settleCycles = 20;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 start;
  logic                 progWrite;
  logic [pcWidth-1:0]   progAddr;
  logic [dataWidth-1:0] progData;
  logic [dataWidth-1:0] inputPort;
  logic [dataWidth-1:0] outputPort;
  logic                 outStrobe;
  logic                 halted;

  integer seed = 32'h4f2a;
  int     errorCount = 0;
  int     failCount = 0;

  // current program, expected and observed OUT values
  logic [dataWidth-1:0] prog [imemDepth];
  int                   progLen;
  logic [dataWidth-1:0] expOut [$];
  logic [dataWidth-1:0] gotOut [$];

  processor UUT (
    .clk(clk), .rst(rst), .start(start), .progWrite(progWrite),
    .progAddr(progAddr), .progData(progData), .inputPort(inputPort),
    .outputPort(outputPort), .outStrobe(outStrobe), .halted(halted)
  );

  always #20 clk = ~clk;

  // collects every strobed output word, cleared by reset
  always @(negedge clk)
  begin
    if (rst)
      gotOut.delete();
    else if (outStrobe)
      gotOut.push_back(outputPort);
  end

  task automatic compareWord(input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp, input string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compareFlag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      errorCount++;
      $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ops that leave a result in rd
  function automatic bit writesReg(input opcode_t op);
    case (op)
      opMov, opAdd, opSub, opAnd, opOr, opNot, opShl, opShr, opLdi, opIn, opLd:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic instrWord_t encode(input opcode_t op,
                                        input logic [regAddrWidth-1:0] rs1);
    instrWord_t w;
    w = '0;
    w.rType.opcode = op;
    w.rType.rs1    = rs1;
    return w;
  endfunction

  // random body, then OUT of every register, HLT, and two dead OUTs
  task automatic makeProgram;
    instrWord_t              w;
    opcode_t                 op;
    logic [regAddrWidth-1:0] lastRd;
    logic [regAddrWidth-1:0] lastStAddr;
    int                      pick;
    lastRd     = '0;
    lastStAddr = '0;
    progLen    = 0;
    for (int i = 0; i < bodyLength; i++)
    begin
      w = instrWord_t'(dataWidth'($random(seed)));
      if (i < (1 << regAddrWidth))
      begin
        // every register starts from an immediate
        w.iType.opcode = opLdi;
        w.iType.rd     = regAddrWidth'(i);
      end
      else
      begin
        pick = int'($unsigned($random(seed)) % 14);
        op   = (pick == 0) ? opNop : opcode_t'(pick + 1);
        w.rType.opcode = op;
        // lean on the last result to build dependency chains
        if ($random(seed) & 1)
          w.rType.rs1 = (op == opLd) ? lastStAddr : lastRd;
        if (($random(seed) & 3) == 0)
          w.rType.rs2 = lastRd;
        if (op == opSt)
          lastStAddr = w.rType.rs1;
      end
      if (writesReg(w.rType.opcode))
        lastRd = w.rType.rd;
      prog[progLen] = w;
      progLen++;
    end
    for (int r = 0; r < (1 << regAddrWidth); r++)
    begin
      prog[progLen] = encode(opOut, regAddrWidth'(r));
      progLen++;
    end
    prog[progLen] = encode(opHlt, '0);
    progLen++;
    // never executed, must not strobe
    prog[progLen] = encode(opOut, 3'd1);
    progLen++;
    prog[progLen] = encode(opOut, 3'd2);
    progLen++;
  endtask

  // sequential ISA interpreter, one instruction at a time
  task automatic runModel(input logic [dataWidth-1:0] portValue);
    logic [dataWidth-1:0] regs [1 << regAddrWidth];
    logic [dataWidth-1:0] mem [dmemDepth];
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    instrWord_t           w;
    int                   pcm;
    bit                   done;
    expOut.delete();
    for (int r = 0; r < (1 << regAddrWidth); r++)
      regs[r] = '0;
    for (int m = 0; m < dmemDepth; m++)
      mem[m] = '0;
    pcm  = 0;
    done = 1'b0;
    while (!done && pcm < progLen)
    begin
      w = instrWord_t'(prog[pcm]);
      a = regs[w.rType.rs1];
      b = regs[w.rType.rs2];
      case (w.rType.opcode)
        opHlt: done = 1'b1;
        opMov: regs[w.rType.rd] = a;
        opAdd: regs[w.rType.rd] = a + b;
        opSub: regs[w.rType.rd] = a - b;
        opAnd: regs[w.rType.rd] = a & b;
        opOr:  regs[w.rType.rd] = a | b;
        opNot: regs[w.rType.rd] = ~a;
        // count in the low nibble of imm
        opShl: regs[w.rType.rd] = a << w.iType.imm[3:0];
        opShr: regs[w.rType.rd] = a >> w.iType.imm[3:0];
        opLdi: regs[w.rType.rd] = {{(dataWidth - 8){w.iType.imm[7]}}, w.iType.imm};
        opIn:  regs[w.rType.rd] = portValue;
        opOut: expOut.push_back(a);
        opLd:  regs[w.rType.rd] = mem[a[7:0]];
        opSt:  mem[a[7:0]] = b;
        default: ;
      endcase
      pcm++;
    end
  endtask

  task automatic resetDut;
    rst       <= 1'b1;
    start     <= 1'b0;
    progWrite <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // idle outputs between reset and start
  task automatic checkIdle;
    @(negedge clk);
    compareFlag(outStrobe, 1'b0, "outStrobe after reset");
    compareFlag(halted, 1'b0, "halted after reset");
    compareWord(outputPort, '0, "outputPort after reset");
  endtask

  task automatic loadProgram;
    for (int a = 0; a < progLen; a++)
    begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= pcWidth'(a);
      progData  <= prog[a];
    end
    @(posedge clk);
    progWrite <= 1'b0;
  endtask

  task automatic waitHalt(output bit ok);
    int cycles;
    cycles = 0;
    while (!halted && cycles < haltTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    ok = halted;
    if (!ok)
    begin
      failCount++;
      $display("Timeout: halted did not rise within %0d cycles", haltTimeout);
    end
  endtask

  task automatic checkOutputs;
    compareFlag(gotOut.size() == expOut.size(), 1'b1,
                $sformatf("strobe count %0d, expected %0d", gotOut.size(), expOut.size()));
    for (int i = 0; i < gotOut.size() && i < expOut.size(); i++)
      compareWord(gotOut[i], expOut[i], $sformatf("OUT number %0d", i));
  endtask

  initial
  begin
    logic [dataWidth-1:0] portValue;
    bit                   ok;
    int                   sizeAtHalt;
    rst       <= 1'b1;
    start     <= 1'b0;
    progWrite <= 1'b0;
    progAddr  <= '0;
    progData  <= '0;
    inputPort <= '0;
    for (int t = 0; t < programCount; t++)
    begin
      resetDut;
      checkIdle;
      makeProgram;
      // one port value per program
      portValue = dataWidth'($random(seed));
      runModel(portValue);
      @(posedge clk);
      inputPort <= portValue;
      loadProgram;
      @(posedge clk);
      start <= 1'b1;
      waitHalt(ok);
      if (ok)
      begin
        @(posedge clk);
        sizeAtHalt = gotOut.size();
        repeat (settleCycles)
        begin
          @(negedge clk);
          compareFlag(halted, 1'b1, "halted stays high");
        end
        @(posedge clk);
        compareFlag(gotOut.size() == sizeAtHalt, 1'b1, "no strobe after HLT");
        checkOutputs;
      end
      @(posedge clk);
    end
    $display("closing: %0d mismatches, %0d other failures", errorCount, failCount);
    if (errorCount == 0 && failCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // datapath and address widths
  localparam int dataWidth = 16;
  localparam int regAddrWidth = 3;
  localparam int pcWidth = 8;

  // memory depths in words
  localparam int imemDepth = 256;
  localparam int dmemDepth = 256;

  // five-bit opcode field, unused codes behave as NOP
  typedef enum logic [4:0] {
    opNop = 5'd0,
    opHlt = 5'd1,
    opMov = 5'd2,
    opAdd = 5'd3,
    opSub = 5'd4,
    opAnd = 5'd5,
    opOr  = 5'd6,
    opNot = 5'd7,
    opShl = 5'd8,
    opShr = 5'd9,
    opLdi = 5'd10,
    opIn  = 5'd11,
    opOut = 5'd12,
    opLd  = 5'd13,
    opSt  = 5'd14
  } opcode_t;

  // operand source in execute
  typedef enum logic [1:0] {
    none      = 2'd0,
    fromExMem = 2'd1,
    fromMemWb = 2'd2
  } fwdSel_t;

  // register format and immediate format over one word
  // shift count sits in imm[3:0], rs1 still in the upper imm bits
  typedef union packed {
    struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs1;
      logic [regAddrWidth-1:0] rs2;
      logic [1:0]              unused;
    } rType;
    struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rd;
      logic [7:0]              imm;
    } iType;
  } instrWord_t;

endpackage

`default_nettype wire

// File: logic/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 memWrite,
  input  logic [dataWidth-1:0] addr,
  input  logic [dataWidth-1:0] writeData,
  output logic [dataWidth-1:0] readData
);

  logic [dataWidth-1:0] mem [dmemDepth];

  // write lands at the edge closing MEM
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < dmemDepth; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (memWrite)
    begin
      mem[addr[$clog2(dmemDepth)-1:0]] <= writeData;
    end
  end

  // combinational read, upper address bits ignored
  assign readData = mem[addr[$clog2(dmemDepth)-1:0]];

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  instrWord_t              instr,
  input  logic                    wbEnable,
  input  logic [regAddrWidth-1:0] wbAddr,
  input  logic [dataWidth-1:0]    wbData,
  output logic [regAddrWidth-1:0] rs1Addr,
  output logic [regAddrWidth-1:0] rs2Addr,
  output logic [regAddrWidth-1:0] rdAddr,
  output logic                    rs1Used,
  output logic                    rs2Used,
  output logic [dataWidth-1:0]    rs1Data,
  output logic [dataWidth-1:0]    rs2Data,
  output logic [dataWidth-1:0]    immValue,
  output opcode_t                 aluOp,
  output logic                    useImm,
  output logic                    regWrite,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    portIn,
  output logic                    portOut,
  output logic                    isHalt
);

  // eight general registers
  logic [dataWidth-1:0] regs [1 << regAddrWidth];

  // register fields from the register view, rd from the immediate view
  assign rs1Addr = instr.rType.rs1;
  assign rs2Addr = instr.rType.rs2;
  assign rdAddr  = instr.iType.rd;

  // sign-extended immediate, low nibble doubles as shift count
  assign immValue = {{(dataWidth - 8){instr.iType.imm[7]}}, instr.iType.imm};

  // opcode passes straight to execute
  assign aluOp = instr.rType.opcode;

  // control decode
  always_comb
  begin
    rs1Used  = 1'b0;
    rs2Used  = 1'b0;
    useImm   = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    portIn   = 1'b0;
    portOut  = 1'b0;
    isHalt   = 1'b0;
    case (instr.rType.opcode)
      opHlt: isHalt = 1'b1;
      opMov, opNot:
      begin
        rs1Used  = 1'b1;
        regWrite = 1'b1;
      end
      opAdd, opSub, opAnd, opOr:
      begin
        rs1Used  = 1'b1;
        rs2Used  = 1'b1;
        regWrite = 1'b1;
      end
      // shift count comes from the immediate
      opShl, opShr:
      begin
        rs1Used  = 1'b1;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      opLdi:
      begin
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      opIn:
      begin
        portIn   = 1'b1;
        regWrite = 1'b1;
      end
      opOut:
      begin
        rs1Used = 1'b1;
        portOut = 1'b1;
      end
      // rs1 holds the address
      opLd:
      begin
        rs1Used  = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      opSt:
      begin
        rs1Used  = 1'b1;
        rs2Used  = 1'b1;
        memWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // register file write from MEM/WB
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < (1 << regAddrWidth); i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wbEnable)
    begin
      regs[wbAddr] <= wbData;
    end
  end

  // same-cycle write passes through to the reads
  assign rs1Data = (wbEnable && wbAddr == rs1Addr) ? wbData : regs[rs1Addr];
  assign rs2Data = (wbEnable && wbAddr == rs2Addr) ? wbData : regs[rs2Addr];

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
  import cpuPkg::*;
(
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  logic [dataWidth-1:0] immValue,
  input  logic                 useImm,
  input  opcode_t              aluOp,
  input  logic [dataWidth-1:0] inputPort,
  input  logic                 portIn,
  input  fwdSel_t              fwdA,
  input  fwdSel_t              fwdB,
  input  logic [dataWidth-1:0] exMemValue,
  input  logic [dataWidth-1:0] memWbValue,
  output logic [dataWidth-1:0] aluResult,
  output logic [dataWidth-1:0] storeData
);

  // operands after forwarding
  logic [dataWidth-1:0] srcA;
  logic [dataWidth-1:0] srcB;
  // second ALU input, register or immediate
  logic [dataWidth-1:0] operandB;
  // ALU output before the port override
  logic [dataWidth-1:0] result;

  // forwarding mux for rs1
  always_comb
  begin
    case (fwdA)
      fromExMem: srcA = exMemValue;
      fromMemWb: srcA = memWbValue;
      default:   srcA = opA;
    endcase
  end

  // forwarding mux for rs2
  always_comb
  begin
    case (fwdB)
      fromExMem: srcB = exMemValue;
      fromMemWb: srcB = memWbValue;
      default:   srcB = opB;
    endcase
  end

  assign operandB = useImm ? immValue : srcB;

  // store data always the forwarded rs2
  assign storeData = srcB;

  always_comb
  begin
    case (aluOp)
      opAdd: result = srcA + operandB;
      opSub: result = srcA - operandB;
      opAnd: result = srcA & operandB;
      opOr:  result = srcA | operandB;
      opNot: result = ~srcA;
      // logical shifts by imm[3:0]
      opShl: result = srcA << operandB[3:0];
      opShr: result = srcA >> operandB[3:0];
      opLdi: result = operandB;
      // MOV, OUT, and the LD/ST address all pass rs1
      default: result = srcA;
    endcase
  end

  // IN takes the port value in place of the ALU
  assign aluResult = portIn ? inputPort : result;

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 progWrite,
  input  logic [pcWidth-1:0]   progAddr,
  input  logic [dataWidth-1:0] progData,
  input  logic                 stall,
  input  logic                 haltSeen,
  output logic [pcWidth-1:0]   pc,
  output instrWord_t           instr
);

  // instruction store filled before start
  logic [dataWidth-1:0] imem [imemDepth];

  // advance only while running
  logic advance;

  assign advance = start && !stall && !haltSeen;

  // program load port locked out once running
  always_ff @(posedge clk)
  begin
    if (progWrite && !start)
    begin
      imem[progAddr] <= progData;
    end
  end

  // program counter
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= '0;
    end
    else if (advance)
    begin
      pc <= pc + pcWidth'(1);
    end
  end

  // word at pc goes into IF/ID in the top level
  assign instr = instrWord_t'(imem[pc]);

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
  import cpuPkg::*;
(
  input  logic [regAddrWidth-1:0] rs1Addr,
  input  logic [regAddrWidth-1:0] rs2Addr,
  input  logic                    rs1Used,
  input  logic                    rs2Used,
  input  logic [regAddrWidth-1:0] exRs1,
  input  logic [regAddrWidth-1:0] exRs2,
  input  logic                    exMemRead,
  input  logic [regAddrWidth-1:0] exRd,
  input  logic                    exMemRegWrite,
  input  logic [regAddrWidth-1:0] exMemRd,
  input  logic                    memWbRegWrite,
  input  logic [regAddrWidth-1:0] memWbRd,
  output fwdSel_t                 fwdA,
  output fwdSel_t                 fwdB,
  output logic                    stall
);

  // newest producer wins
  function automatic fwdSel_t pickSource(input logic [regAddrWidth-1:0] src);
    if (exMemRegWrite && exMemRd == src)
      return fromExMem;
    else if (memWbRegWrite && memWbRd == src)
      return fromMemWb;
    else
      return none;
  endfunction

  assign fwdA = pickSource(exRs1);
  assign fwdB = pickSource(exRs2);

  // load in execute feeding a real read in decode
  assign stall = exMemRead &&
                 ((rs1Used && exRd == rs1Addr) || (rs2Used && exRd == rs2Addr));

endmodule

`default_nettype wire

// File: logic/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 progWrite,
  input  logic [pcWidth-1:0]   progAddr,
  input  logic [dataWidth-1:0] progData,
  input  logic [dataWidth-1:0] inputPort,
  output logic [dataWidth-1:0] outputPort,
  output logic                 outStrobe,
  output logic                 halted
);

  // fetch and IF/ID
  instrWord_t fetchInstr;
  instrWord_t ifIdInstr;
  logic       haltSeen;

  // decode outputs
  logic [regAddrWidth-1:0] idRs1Addr, idRs2Addr, idRdAddr;
  logic                    idRs1Used, idRs2Used;
  logic [dataWidth-1:0]    idRs1Data, idRs2Data, idImm;
  opcode_t                 idAluOp;
  logic                    idUseImm, idRegWrite, idMemRead, idMemWrite;
  logic                    idPortIn, idPortOut, idHalt;

  // ID/EX
  logic [regAddrWidth-1:0] idExRs1, idExRs2, idExRd;
  logic [dataWidth-1:0]    idExOpA, idExOpB, idExImm;
  opcode_t                 idExAluOp;
  logic                    idExUseImm, idExRegWrite, idExMemRead, idExMemWrite;
  logic                    idExPortIn, idExPortOut, idExHalt;

  // execute and hazard
  fwdSel_t              fwdA, fwdB;
  logic                 stall;
  logic [dataWidth-1:0] exResult, exStoreData;

  // EX/MEM
  logic [dataWidth-1:0]    exMemResult, exMemStoreData;
  logic [regAddrWidth-1:0] exMemRd;
  logic                    exMemRegWrite, exMemMemRead, exMemMemWrite;
  logic                    exMemPortOut, exMemHalt;

  // MEM/WB and writeback
  logic [dataWidth-1:0]    memReadData;
  logic [dataWidth-1:0]    memWbResult, memWbReadData, wbData;
  logic [regAddrWidth-1:0] memWbRd;
  logic                    memWbRegWrite, memWbMemRead, memWbPortOut, memWbHalt;

  // pc has no consumer without branches
  fetchStage fetch (
    .clk(clk), .rst(rst), .start(start), .progWrite(progWrite),
    .progAddr(progAddr), .progData(progData), .stall(stall),
    .haltSeen(haltSeen), .pc(), .instr(fetchInstr)
  );

  decodeStage decode (
    .clk(clk), .rst(rst), .instr(ifIdInstr),
    .wbEnable(memWbRegWrite), .wbAddr(memWbRd), .wbData(wbData),
    .rs1Addr(idRs1Addr), .rs2Addr(idRs2Addr), .rdAddr(idRdAddr),
    .rs1Used(idRs1Used), .rs2Used(idRs2Used),
    .rs1Data(idRs1Data), .rs2Data(idRs2Data), .immValue(idImm),
    .aluOp(idAluOp), .useImm(idUseImm), .regWrite(idRegWrite),
    .memRead(idMemRead), .memWrite(idMemWrite),
    .portIn(idPortIn), .portOut(idPortOut), .isHalt(idHalt)
  );

  hazardUnit hazard (
    .rs1Addr(idRs1Addr), .rs2Addr(idRs2Addr),
    .rs1Used(idRs1Used), .rs2Used(idRs2Used),
    .exRs1(idExRs1), .exRs2(idExRs2), .exMemRead(idExMemRead), .exRd(idExRd),
    .exMemRegWrite(exMemRegWrite), .exMemRd(exMemRd),
    .memWbRegWrite(memWbRegWrite), .memWbRd(memWbRd),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
  );

  executeStage execute (
    .opA(idExOpA), .opB(idExOpB), .immValue(idExImm), .useImm(idExUseImm),
    .aluOp(idExAluOp), .inputPort(inputPort), .portIn(idExPortIn),
    .fwdA(fwdA), .fwdB(fwdB), .exMemValue(exMemResult), .memWbValue(wbData),
    .aluResult(exResult), .storeData(exStoreData)
  );

  dataMemory dmem (
    .clk(clk), .rst(rst), .memWrite(exMemMemWrite), .addr(exMemResult),
    .writeData(exMemStoreData),
    .readData(memReadData)
  );

  // load data or ALU result
  assign wbData = memWbMemRead ? memWbReadData : memWbResult;

  // IF/ID is cleared behind HLT and held on stall
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ifIdInstr <= '0;
      haltSeen  <= 1'b0;
    end
    else
    begin
      if (idHalt)
        haltSeen <= 1'b1;
      if (idHalt || haltSeen)
        ifIdInstr <= '0;
      else if (start && !stall)
        ifIdInstr <= fetchInstr;
    end
  end

  // ID/EX takes a bubble on stall
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      {idExRs1, idExRs2, idExRd, idExOpA, idExOpB, idExImm} <= '0;
      idExAluOp <= opNop;
      {idExUseImm, idExRegWrite, idExMemRead, idExMemWrite} <= '0;
      {idExPortIn, idExPortOut, idExHalt} <= '0;
    end
    else
    begin
      idExRs1    <= idRs1Addr;
      idExRs2    <= idRs2Addr;
      idExRd     <= idRdAddr;
      idExOpA    <= idRs1Data;
      idExOpB    <= idRs2Data;
      idExImm    <= idImm;
      idExUseImm <= idUseImm;
      idExPortIn <= idPortIn;
      // stall turns the slot into a NOP
      idExAluOp    <= stall ? opNop : idAluOp;
      idExRegWrite <= idRegWrite && !stall;
      idExMemRead  <= idMemRead && !stall;
      idExMemWrite <= idMemWrite && !stall;
      idExPortOut  <= idPortOut && !stall;
      idExHalt     <= idHalt && !stall;
    end
  end

  // EX/MEM and MEM/WB
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      {exMemResult, exMemStoreData, exMemRd} <= '0;
      {exMemRegWrite, exMemMemRead, exMemMemWrite, exMemPortOut, exMemHalt} <= '0;
      {memWbResult, memWbReadData, memWbRd} <= '0;
      {memWbRegWrite, memWbMemRead, memWbPortOut, memWbHalt} <= '0;
    end
    else
    begin
      exMemResult    <= exResult;
      exMemStoreData <= exStoreData;
      exMemRd        <= idExRd;
      exMemRegWrite  <= idExRegWrite;
      exMemMemRead   <= idExMemRead;
      exMemMemWrite  <= idExMemWrite;
      exMemPortOut   <= idExPortOut;
      exMemHalt      <= idExHalt;
      memWbResult    <= exMemResult;
      memWbReadData  <= memReadData;
      memWbRd        <= exMemRd;
      memWbRegWrite  <= exMemRegWrite;
      memWbMemRead   <= exMemMemRead;
      memWbPortOut   <= exMemPortOut;
      memWbHalt      <= exMemHalt;
    end
  end

  // output port, strobe and halt flag at the end of writeback
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      outputPort <= '0;
      outStrobe  <= 1'b0;
      halted     <= 1'b0;
    end
    else
    begin
      outStrobe <= memWbPortOut;
      if (memWbPortOut)
        outputPort <= wbData;
      if (memWbHalt)
        halted <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module processorTb -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/VprocessorTb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: sim.f
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/dataMemory.sv
logic/processor.sv
dv/processorTb.sv
